/* bus_pkg.sv */
package bus_pkg;

    localparam int BUS_ADDR_W = 32;

    // requester ids on the shared read bus
    typedef enum logic {
        REQ_ICACHE = 1'b0,
        REQ_LOAD   = 1'b1
    } req_id_e;

    // request from one requester to the arbiter
    typedef struct packed {
        logic                  ren;  // held until accepted
        logic [BUS_ADDR_W-1:0] addr; // line aligned
    } bus_req_t;

endpackage

/* cache_pkg.sv */
package cache_pkg;

    localparam int ADDR_W       = 32;
    localparam int WORD_W       = 32;
    localparam int LINE_BYTES   = 16;
    localparam int LINE_WORDS   = LINE_BYTES / (WORD_W / 8);
    localparam int OFFSET_W     = $clog2(LINE_BYTES);
    localparam int WORD_SEL_W   = $clog2(LINE_WORDS);
    localparam int DEFAULT_SETS = 64;
    localparam int MIN_SETS     = 4;
    localparam int TAG_W        = ADDR_W - OFFSET_W - $clog2(DEFAULT_SETS);
    localparam int TAG_MAX_W    = ADDR_W - OFFSET_W - $clog2(MIN_SETS); // widest tag, fewest sets

    typedef logic [WORD_W-1:0] word_t;
    typedef word_t [LINE_WORDS-1:0] line_t; // word 0 at lowest address

    typedef struct packed {
        logic                 valid;
        logic [TAG_MAX_W-1:0] tag;
        line_t                data;
    } way_entry_t;

    function automatic logic [ADDR_W-1:0] line_base(input logic [ADDR_W-1:0] a);
        return {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    endfunction

    function automatic word_t pick_word(input line_t l, input logic [ADDR_W-1:0] a);
        return l[a[OFFSET_W-1 -: WORD_SEL_W]];
    endfunction

endpackage

/* fetch_chk.sv */
`timescale 1ns/1ps
module fetch_chk
    import bus_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic ic_accepted,
    input logic ld_accepted,
    input logic ic_rvalid,
    input logic ld_rvalid,
    input logic dev_rvalid,
    input logic cpu_ren
);

    logic    held_q;   // accepted read still waiting for data
    req_id_e holder_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            held_q   <= 1'b0;
            holder_q <= REQ_ICACHE;
        end
        else if (ic_accepted || ld_accepted)
        begin
            held_q   <= 1'b1;
            holder_q <= ld_accepted ? REQ_LOAD : REQ_ICACHE;
        end
        else if (dev_rvalid)
            held_q <= 1'b0;
    end

    one_accept: assert property (@(posedge clk) disable iff (rst)
        (ic_accepted || ld_accepted) |-> (!(ic_accepted && ld_accepted) && !held_q))
        else $error("more than one read accepted at a time");

    ic_rvalid_owner: assert property (@(posedge clk) disable iff (rst)
        ic_rvalid |-> (held_q && holder_q == REQ_ICACHE))
        else $error("cache got data-valid without holding the grant");

    ld_rvalid_owner: assert property (@(posedge clk) disable iff (rst)
        ld_rvalid |-> (held_q && holder_q == REQ_LOAD))
        else $error("reader got data-valid without holding the grant");

    // a new read only starts once the bus is free again
    ren_when_free: assert property (@(posedge clk) disable iff (rst)
        cpu_ren |-> !held_q)
        else $error("cpu_ren raised while a grant was held");

endmodule

/* fetch_patterns.txt */
// cmd: 1 fetch, 2 load, 3 flush during refill then fetch, 4 fetch with concurrent load
// cmd _ expected bus reads _ fetch or load address _ load address for cmd 4
1_1_00000100_00000000
1_0_00000104_00000000
1_0_00000100_00000000
1_2_0000020c_00000000
1_1_00001040_00000000
1_1_00002040_00000000
1_0_00001040_00000000
1_1_00003040_00000000
1_0_00001040_00000000
2_1_80000008_00000000
2_1_8000001c_00000000
4_2_00000380_80000024
4_2_000004f8_80000030
3_2_00000640_00000000
1_0_00000640_00000000
1_1_00002040_00000000

/* fetch_subsys.sv */
`timescale 1ns/1ps
module fetch_subsys
    import cache_pkg::*;
    import bus_pkg::*;
#(
    parameter int NUM_SETS = 64
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  inst_rreq,
    input  logic [31:0]           inst_addr,
    output logic                  inst_valid,
    output logic [31:0]           inst_out1,
    output logic [31:0]           inst_out2,
    output logic [31:0]           pc1,
    output logic [31:0]           pc2,
    output logic                  pc_suspend,
    input  logic                  load_req,
    input  logic [31:0]           load_addr,
    output logic                  load_valid,
    output logic [31:0]           load_data,
    output logic                  load_busy,
    output logic                  cpu_ren,
    output logic [BUS_ADDR_W-1:0] cpu_raddr,
    input  logic                  dev_rrdy,
    input  logic                  ren_received,
    input  logic                  dev_rvalid,
    input  line_t                 dev_rdata
);

    bus_req_t ic_req;
    bus_req_t ld_req;
    logic     ic_rdy, ic_accepted, ic_rvalid;
    logic     ld_rdy, ld_accepted, ld_rvalid;
    line_t    rdata;

    icache #(
        .NUM_SETS (NUM_SETS)
    ) u_icache (
        .clk, .rst, .flush, .inst_rreq, .inst_addr,
        .inst_valid, .inst_out1, .inst_out2, .pc1, .pc2, .pc_suspend,
        .req          (ic_req),
        .bus_rdy      (ic_rdy),
        .bus_accepted (ic_accepted),
        .bus_rvalid   (ic_rvalid),
        .bus_rdata    (rdata)
    );

    uncached_reader u_reader (
        .clk, .rst, .load_req, .load_addr, .load_valid, .load_data, .load_busy,
        .req          (ld_req),
        .bus_rdy      (ld_rdy),
        .bus_accepted (ld_accepted),
        .bus_rvalid   (ld_rvalid),
        .bus_rdata    (rdata)
    );

    mem_arbiter u_arbiter (
        .clk, .rst, .ic_req, .ld_req,
        .ic_rdy, .ld_rdy, .ic_accepted, .ld_accepted, .ic_rvalid, .ld_rvalid,
        .rdata, .cpu_ren, .cpu_raddr, .dev_rrdy, .ren_received, .dev_rvalid, .dev_rdata
    );

endmodule

/* icache.sv */
`timescale 1ns/1ps
module icache
    import cache_pkg::*;
    import bus_pkg::*;
#(
    parameter int NUM_SETS = 64
)
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        inst_rreq,
    input  logic [31:0] inst_addr,
    output logic        inst_valid,
    output logic [31:0] inst_out1,
    output logic [31:0] inst_out2,
    output logic [31:0] pc1,
    output logic [31:0] pc2,
    output logic        pc_suspend,
    output bus_req_t    req,
    input  logic        bus_rdy,
    input  logic        bus_accepted,
    input  logic        bus_rvalid,
    input  line_t       bus_rdata
);

    localparam int INDEX_W  = $clog2(NUM_SETS);
    localparam int TAG_BITS = TAG_W + $clog2(DEFAULT_SETS) - INDEX_W;

    typedef struct packed {
        logic [ADDR_W-1:0] pc1;
        logic [ADDR_W-1:0] pc2;
    } fetch_pair_t;

    typedef enum logic [1:0] {R_IDLE, R_REQ, R_WAIT} refill_state_e;

    function automatic logic [INDEX_W-1:0] index_of(input logic [ADDR_W-1:0] a);
        return a[OFFSET_W +: INDEX_W];
    endfunction

    function automatic logic [TAG_MAX_W-1:0] tag_of(input logic [ADDR_W-1:0] a);
        logic [TAG_BITS-1:0] t;
        t = a[ADDR_W-1 -: TAG_BITS];
        return TAG_MAX_W'(t);
    endfunction

    fetch_pair_t         s1_pair;
    fetch_pair_t         s2_pair_q;
    logic                s2_req_q;
    refill_state_e       state_q;
    logic                stale_q;  // refill outlived a flush
    logic [ADDR_W-1:0]   refill_addr_q;
    logic [NUM_SETS-1:0] lru_q;    // way to replace next

    way_entry_t         w0_e1, w0_e2, w1_e1, w1_e2;
    way_entry_t         refill_entry;
    logic [INDEX_W-1:0] rd_idx1, rd_idx2, wr_idx;
    logic               live;
    logic               hit1_w0, hit1_w1, hit2_w0, hit2_w1, hit1, hit2;
    logic               miss1, miss2, refill_done, we0, we1;
    line_t              line1, line2;

    assign s1_pair = '{pc1: inst_addr, pc2: inst_addr + 32'd4};

    // stage two: tag compare and word pick
    assign live    = s2_req_q & ~flush;
    assign hit1_w0 = live & w0_e1.valid & (w0_e1.tag == tag_of(s2_pair_q.pc1));
    assign hit1_w1 = live & w1_e1.valid & (w1_e1.tag == tag_of(s2_pair_q.pc1));
    assign hit2_w0 = live & w0_e2.valid & (w0_e2.tag == tag_of(s2_pair_q.pc2));
    assign hit2_w1 = live & w1_e2.valid & (w1_e2.tag == tag_of(s2_pair_q.pc2));
    assign hit1    = hit1_w0 | hit1_w1;
    assign hit2    = hit2_w0 | hit2_w1;
    assign miss1   = live & ~hit1;
    assign miss2   = live & ~hit2;

    assign pc_suspend = miss1 | miss2;
    assign inst_valid = hit1 & hit2;
    assign line1      = hit1_w1 ? w1_e1.data : w0_e1.data;
    assign line2      = hit2_w1 ? w1_e2.data : w0_e2.data;
    assign inst_out1  = pick_word(line1, s2_pair_q.pc1);
    assign inst_out2  = pick_word(line2, s2_pair_q.pc2);
    assign pc1        = s2_pair_q.pc1;
    assign pc2        = s2_pair_q.pc2;

    // hold stage-two indices while stalled so the refilled line is read back
    assign rd_idx1 = pc_suspend ? index_of(s2_pair_q.pc1) : index_of(s1_pair.pc1);
    assign rd_idx2 = pc_suspend ? index_of(s2_pair_q.pc2) : index_of(s1_pair.pc2);

    always_ff @(posedge clk)
    begin
        if (rst || flush)
            s2_req_q <= 1'b0;
        else if (!pc_suspend)
            s2_req_q <= inst_rreq;
    end

    always_ff @(posedge clk)
    begin
        if (!pc_suspend)
            s2_pair_q <= s1_pair;
    end

    // refill control
    assign refill_done  = (state_q == R_WAIT) & bus_rvalid;
    assign wr_idx       = index_of(refill_addr_q);
    assign we0          = refill_done & ~stale_q & ~flush & ~lru_q[wr_idx];
    assign we1          = refill_done & ~stale_q & ~flush & lru_q[wr_idx];
    assign refill_entry = '{valid: 1'b1, tag: tag_of(refill_addr_q), data: bus_rdata};
    assign req          = '{ren: (state_q == R_REQ), addr: refill_addr_q};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= R_IDLE;
            stale_q <= 1'b0;
        end
        else
        begin
            case (state_q)
                R_IDLE:
                    if (pc_suspend && bus_rdy)
                        state_q <= R_REQ;
                R_REQ:
                    if (bus_accepted)
                        state_q <= R_WAIT;
                R_WAIT:
                    if (bus_rvalid)
                        state_q <= R_IDLE;
                default:
                    state_q <= R_IDLE;
            endcase
            if (refill_done)
                stale_q <= 1'b0;
            else if (flush && state_q != R_IDLE)
                stale_q <= 1'b1; // data still comes, but is dropped
        end
    end

    always_ff @(posedge clk)
    begin
        if (state_q == R_IDLE && pc_suspend)
            refill_addr_q <= line_base(miss1 ? s2_pair_q.pc1 : s2_pair_q.pc2);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            lru_q <= '0;
        else if (we0 || we1)
            lru_q[wr_idx] <= ~lru_q[wr_idx];
        else if (inst_valid)
        begin
            lru_q[index_of(s2_pair_q.pc1)] <= ~hit1_w1;
            lru_q[index_of(s2_pair_q.pc2)] <= ~hit2_w1;
        end
    end

    icache_ram #(
        .NUM_SETS (NUM_SETS)
    ) ram_way0 (
        .clk      (clk),
        .rst      (rst),
        .we       (we0),
        .w_index  (wr_idx),
        .w_data   (refill_entry),
        .r_index1 (rd_idx1),
        .r_index2 (rd_idx2),
        .r_data1  (w0_e1),
        .r_data2  (w0_e2)
    );

    icache_ram #(
        .NUM_SETS (NUM_SETS)
    ) ram_way1 (
        .clk      (clk),
        .rst      (rst),
        .we       (we1),
        .w_index  (wr_idx),
        .w_data   (refill_entry),
        .r_index1 (rd_idx1),
        .r_index2 (rd_idx2),
        .r_data1  (w1_e1),
        .r_data2  (w1_e2)
    );

endmodule

/* icache_ram.sv */
`timescale 1ns/1ps
module icache_ram
    import cache_pkg::*;
#(
    parameter int NUM_SETS = 64
)
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        we,
    input  logic [$clog2(NUM_SETS)-1:0] w_index,
    input  way_entry_t                  w_data,
    input  logic [$clog2(NUM_SETS)-1:0] r_index1,
    input  logic [$clog2(NUM_SETS)-1:0] r_index2,
    output way_entry_t                  r_data1,
    output way_entry_t                  r_data2
);

    localparam int INDEX_W = $clog2(NUM_SETS);

    logic [TAG_MAX_W-1:0] tag_mem [NUM_SETS];
    line_t                data_mem [NUM_SETS];
    logic [NUM_SETS-1:0]  valid_q;
    logic [INDEX_W-1:0]   r_index1_q;
    logic [INDEX_W-1:0]   r_index2_q;

    always_ff @(posedge clk)
    begin
        if (rst)
            valid_q <= '0;
        else if (we)
            valid_q[w_index] <= w_data.valid;
    end

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            tag_mem[w_index]  <= w_data.tag;
            data_mem[w_index] <= w_data.data;
        end
        r_index1_q <= r_index1;
        r_index2_q <= r_index2;
    end

    // read sees a write made after the index was registered
    assign r_data1 = '{valid: valid_q[r_index1_q], tag: tag_mem[r_index1_q],
                       data: data_mem[r_index1_q]};
    assign r_data2 = '{valid: valid_q[r_index2_q], tag: tag_mem[r_index2_q],
                       data: data_mem[r_index2_q]};

endmodule

/* list.f */
cache_pkg.sv
bus_pkg.sv
icache_ram.sv
icache.sv
uncached_reader.sv
mem_arbiter.sv
fetch_subsys.sv
fetch_chk.sv
tb_fetch_subsys.sv

/* mem_arbiter.sv */
`timescale 1ns/1ps
module mem_arbiter
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  bus_req_t              ic_req,
    input  bus_req_t              ld_req,
    output logic                  ic_rdy,
    output logic                  ld_rdy,
    output logic                  ic_accepted,
    output logic                  ld_accepted,
    output logic                  ic_rvalid,
    output logic                  ld_rvalid,
    output line_t                 rdata,
    output logic                  cpu_ren,
    output logic [BUS_ADDR_W-1:0] cpu_raddr,
    input  logic                  dev_rrdy,
    input  logic                  ren_received,
    input  logic                  dev_rvalid,
    input  line_t                 dev_rdata
);

    req_id_e owner_q;
    req_id_e last_q;     // winner of the previous grant
    req_id_e pend_id_q;
    req_id_e pick;
    req_id_e sel;
    logic    owner_valid_q;
    logic    pend_q;     // request on the bus, not yet accepted

    always_comb
    begin
        if (ic_req.ren && ld_req.ren)
            pick = (last_q == REQ_ICACHE) ? REQ_LOAD : REQ_ICACHE;
        else if (ld_req.ren)
            pick = REQ_LOAD;
        else
            pick = REQ_ICACHE;
    end

    // keep the choice stable until the responder takes it
    assign sel       = pend_q ? pend_id_q : pick;
    assign cpu_ren   = ~owner_valid_q & (ic_req.ren | ld_req.ren);
    assign cpu_raddr = (sel == REQ_LOAD) ? ld_req.addr : ic_req.addr;

    assign ic_rdy = dev_rrdy & ~(owner_valid_q & (owner_q == REQ_LOAD));
    assign ld_rdy = dev_rrdy & ~(owner_valid_q & (owner_q == REQ_ICACHE));

    assign ic_accepted = ren_received & cpu_ren & (sel == REQ_ICACHE);
    assign ld_accepted = ren_received & cpu_ren & (sel == REQ_LOAD);
    assign ic_rvalid   = dev_rvalid & owner_valid_q & (owner_q == REQ_ICACHE);
    assign ld_rvalid   = dev_rvalid & owner_valid_q & (owner_q == REQ_LOAD);
    assign rdata       = dev_rdata;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            owner_valid_q <= 1'b0;
            owner_q       <= REQ_ICACHE;
            last_q        <= REQ_LOAD; // cache wins the first tie
            pend_q        <= 1'b0;
            pend_id_q     <= REQ_ICACHE;
        end
        else
        begin
            pend_q <= cpu_ren & ~ren_received;
            if (cpu_ren && !pend_q)
                pend_id_q <= pick;
            if (cpu_ren && ren_received)
            begin
                owner_valid_q <= 1'b1;
                owner_q       <= sel;
                last_q        <= sel;
            end
            else if (dev_rvalid && owner_valid_q)
                owner_valid_q <= 1'b0;
        end
    end

endmodule

/* tb_fetch_subsys.sv */
`timescale 1ns/1ps
module tb_fetch_subsys
    import cache_pkg::*;
();

    localparam int          MAX_PATS  = 64;
    localparam logic [31:0] MEM_KEY   = 32'h5a3c_96e1;
    localparam logic [3:0]  CMD_FETCH = 4'd1;
    localparam logic [3:0]  CMD_LOAD  = 4'd2;
    localparam logic [3:0]  CMD_FLUSH = 4'd3;
    localparam logic [3:0]  CMD_BOTH  = 4'd4;

    logic        clk;
    logic        rst          = 1'b1;
    logic        flush        = 1'b0;
    logic        inst_rreq    = 1'b0;
    logic [31:0] inst_addr    = '0;
    logic        load_req     = 1'b0;
    logic [31:0] load_addr    = '0;
    logic        dev_rrdy     = 1'b0;
    logic        ren_received = 1'b0;
    logic        dev_rvalid   = 1'b0;
    line_t       dev_rdata    = '0;
    logic        inst_valid;
    logic        pc_suspend;
    logic        load_valid;
    logic        load_busy;
    logic        cpu_ren;
    logic [31:0] inst_out1;
    logic [31:0] inst_out2;
    logic [31:0] pc1;
    logic [31:0] pc2;
    logic [31:0] load_data;
    logic [31:0] cpu_raddr;

    logic [71:0] pats [0:MAX_PATS-1]; // cmd, reads, addr a, addr b
    int          n_pats     = 0;
    logic        pats_ready = 1'b0;
    int          n_checks   = 0;
    int          n_errors   = 0;
    int          ren_rises  = 0;
    logic        cpu_ren_q  = 1'b0;
    logic [3:0]  cmd;
    logic [3:0]  exp_reads;
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    string       name;
    int          rises_before;

    logic [31:0] lfsr     = 32'h691d_c371;
    logic [1:0]  rdy_bits;
    logic [1:0]  delay_bits;
    logic        rsp_busy = 1'b0;
    logic [31:0] rsp_base;
    int          rsp_wait;

    fetch_subsys DUT (.*);

    bind mem_arbiter fetch_chk arb_chk (
        .clk         (clk),
        .rst         (rst),
        .ic_accepted (ic_accepted),
        .ld_accepted (ld_accepted),
        .ic_rvalid   (ic_rvalid),
        .ld_rvalid   (ld_rvalid),
        .dev_rvalid  (dev_rvalid),
        .cpu_ren     (cpu_ren)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32,22,2,1
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ MEM_KEY;
    endfunction

    function automatic line_t line_at(input logic [31:0] base);
        line_t l;
        for (int w = 0; w < 4; w++)
            l[w] = word_at(base + 32'(4 * w));
        return l;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        n_checks++;
        if (actual !== expected)
        begin
            n_errors++;
            $display("** Error %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    task automatic fetch_pair(input logic [31:0] a, input string what);
        @(posedge clk);
        inst_rreq <= 1'b1;
        inst_addr <= a;
        @(posedge clk);
        inst_rreq <= 1'b0; // registered at this edge
        @(posedge clk);
        check_value({what, " hit or stall"}, 32'd1, 32'(inst_valid ^ pc_suspend));
        while (!inst_valid)
            @(posedge clk);
        check_value({what, " pc1"}, a, pc1);
        check_value({what, " pc2"}, a + 32'd4, pc2);
        check_value({what, " inst_out1"}, word_at(a), inst_out1);
        check_value({what, " inst_out2"}, word_at(a + 32'd4), inst_out2);
    endtask

    task automatic uncached_load(input logic [31:0] a, input string what);
        logic busy_seen;
        busy_seen = 1'b0;
        @(posedge clk);
        load_req  <= 1'b1;
        load_addr <= a;
        do
        begin
            @(posedge clk);
            busy_seen = busy_seen | load_busy;
        end
        while (!load_valid);
        load_req <= 1'b0;
        check_value({what, " load_busy seen"}, 32'd1, 32'(busy_seen));
        check_value({what, " load_data"}, word_at(a), load_data);
    endtask

    task automatic flush_during_refill(input logic [31:0] a, input string what);
        int start;
        start = ren_rises;
        @(posedge clk);
        inst_rreq <= 1'b1;
        inst_addr <= a;
        @(posedge clk);
        inst_rreq <= 1'b0;
        do
            @(posedge clk);
        while (ren_rises == start); // refill on its way
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        fetch_pair(a, what);
    endtask

    // memory model, one read at a time
    always @(posedge clk)
    begin
        if (rst)
        begin
            dev_rrdy     <= 1'b0;
            ren_received <= 1'b0;
            dev_rvalid   <= 1'b0;
            rsp_busy = 1'b0;
        end
        else
        begin
            for (int k = 0; k < 2; k++)
            begin
                lfsr = lfsr_next(lfsr);
                rdy_bits[k] = lfsr[0];
            end
            dev_rrdy     <= |rdy_bits; // low about one cycle in four
            ren_received <= 1'b0;
            dev_rvalid   <= 1'b0;
            if (ren_received && cpu_ren)
            begin
                for (int k = 0; k < 2; k++)
                begin
                    lfsr = lfsr_next(lfsr);
                    delay_bits[k] = lfsr[0];
                end
                rsp_base = cpu_raddr;
                rsp_wait = 2 + int'(delay_bits);
                rsp_busy = 1'b1;
            end
            else if (rsp_busy)
            begin
                rsp_wait--;
                if (rsp_wait == 0)
                begin
                    dev_rvalid <= 1'b1;
                    dev_rdata  <= line_at(rsp_base);
                    rsp_busy = 1'b0;
                end
            end
            else if (cpu_ren && dev_rrdy && !ren_received)
                ren_received <= 1'b1;
        end
    end

    // bus read count and data seen with inst_valid
    always @(posedge clk)
    begin
        if (!rst)
        begin
            if (cpu_ren && !cpu_ren_q)
                ren_rises <= ren_rises + 1;
            if (inst_valid)
            begin
                check_value("valid monitor inst_out1", word_at(pc1), inst_out1);
                check_value("valid monitor inst_out2", word_at(pc2), inst_out2);
            end
        end
        cpu_ren_q = cpu_ren;
    end

    initial
    begin
        wait (pats_ready);
        repeat (n_pats * 40 + 20) @(posedge clk);
        $display("watchdog: %0d patterns did not finish within %0d cycles",
                 n_pats, n_pats * 40 + 20);
        $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        for (int p = 0; p < MAX_PATS; p++)
            pats[p] = '0;
        $readmemh("fetch_patterns.txt", pats);
        while (n_pats < MAX_PATS && pats[n_pats][71:68] != 4'd0)
            n_pats++;
        pats_ready = 1'b1;
        if (n_pats == 0)
        begin
            $display("no patterns found in fetch_patterns.txt");
            n_errors++;
        end

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("reset cpu_ren", 32'd0, 32'(cpu_ren));
        check_value("reset inst_valid", 32'd0, 32'(inst_valid));
        check_value("reset pc_suspend", 32'd0, 32'(pc_suspend));
        check_value("reset load_valid", 32'd0, 32'(load_valid));
        check_value("reset load_busy", 32'd0, 32'(load_busy));

        for (int i = 0; i < n_pats; i++)
        begin
            cmd          = pats[i][71:68];
            exp_reads    = pats[i][67:64];
            addr_a       = pats[i][63:32];
            addr_b       = pats[i][31:0];
            name         = $sformatf("pattern %0d", i);
            rises_before = ren_rises;
            case (cmd)
                CMD_FETCH:
                    fetch_pair(addr_a, name);
                CMD_LOAD:
                    uncached_load(addr_a, name);
                CMD_FLUSH:
                    flush_during_refill(addr_a, name);
                CMD_BOTH:
                    fork
                        fetch_pair(addr_a, name);
                        uncached_load(addr_b, name);
                    join
                default:
                begin
                    $display("pattern %0d has an unknown command %0h", i, cmd);
                    n_errors++;
                end
            endcase
            repeat (2) @(posedge clk); // catch stray reads
            check_value({name, " bus reads"}, 32'(exp_reads), 32'(ren_rises - rises_before));
        end

        repeat (4) @(posedge clk);
        $display("%0d patterns, %0d checks, %0d errors", n_pats, n_checks, n_errors);
        if (n_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* uncached_reader.sv */
`timescale 1ns/1ps
module uncached_reader
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        load_req,
    input  logic [31:0] load_addr,
    output logic        load_valid,
    output logic [31:0] load_data,
    output logic        load_busy,
    output bus_req_t    req,
    input  logic        bus_rdy,
    input  logic        bus_accepted,
    input  logic        bus_rvalid,
    input  line_t       bus_rdata
);

    typedef enum logic [1:0] {L_IDLE, L_ACCEPT, L_DATA} load_state_e;

    load_state_e       state_q;
    logic [ADDR_W-1:0] addr_q;

    assign req       = '{ren: (state_q == L_ACCEPT), addr: line_base(addr_q)};
    assign load_busy = (state_q != L_IDLE);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q    <= L_IDLE;
            load_valid <= 1'b0;
        end
        else
        begin
            load_valid <= (state_q == L_DATA) & bus_rvalid;
            case (state_q)
                L_IDLE:
                    if (load_req && bus_rdy && !load_valid) // request still up on the done cycle
                        state_q <= L_ACCEPT;
                L_ACCEPT:
                    if (bus_accepted)
                        state_q <= L_DATA;
                L_DATA:
                    if (bus_rvalid)
                        state_q <= L_IDLE;
                default:
                    state_q <= L_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state_q == L_IDLE)
            addr_q <= load_addr;
        if (state_q == L_DATA && bus_rvalid)
            load_data <= pick_word(bus_rdata, addr_q);
    end

endmodule
